// File: hw/sfr_pkg.sv
// ==============================
// SFR addresses and bit positions
// of the 8051 timer/interrupt block
// ==============================
`default_nettype none

package sfr_pkg;

    // ==============================
    // Register addresses
    // ==============================
    localparam logic [7:0] TCON_ADDR = 8'h88;
    localparam logic [7:0] TMOD_ADDR = 8'h89;
    localparam logic [7:0] TL0_ADDR  = 8'h8A;
    localparam logic [7:0] TL1_ADDR  = 8'h8B;
    localparam logic [7:0] TH0_ADDR  = 8'h8C;
    localparam logic [7:0] TH1_ADDR  = 8'h8D;
    localparam logic [7:0] IE_ADDR   = 8'hA8;
    localparam logic [7:0] IP_ADDR   = 8'hB8;

    // TCON flags and run bits
    localparam int TCON_TF1_INDEX = 7;
    localparam int TCON_TR1_INDEX = 6;
    localparam int TCON_TF0_INDEX = 5;
    localparam int TCON_TR0_INDEX = 4;

    // IE enables, EA is the global gate
    localparam int IE_EA_INDEX  = 7;
    localparam int IE_ET1_INDEX = 3;
    localparam int IE_EX1_INDEX = 2;
    localparam int IE_ET0_INDEX = 1;
    localparam int IE_EX0_INDEX = 0;

    // TMOD nibble offsets, then fields inside a nibble
    localparam int TMOD_T1_SHIFT   = 4;
    localparam int TMOD_T0_SHIFT   = 0;
    localparam int TMOD_GATE_INDEX = 3;
    localparam int TMOD_C_T_INDEX  = 2;
    localparam int TMOD_M1_INDEX   = 1;
    localparam int TMOD_M0_INDEX   = 0;

endpackage

`default_nettype wire

// File: hw/periph_pkg.sv
// ==============================
// Peripheral widths, interrupt sources and vectors
// ==============================
`default_nettype none

package periph_pkg;

    // SFR bus data and address width
    localparam int DATA_WIDTH = 8;

    // ==============================
    // Interrupt sources
    // ==============================
    localparam int NUM_OF_INT  = 4;
    localparam int NUM_OF_INTX = 2;

    // Source index, lower index wins within a level
    localparam int INT_EXT0   = 0;
    localparam int INT_TIMER0 = 1;
    localparam int INT_EXT1   = 2;
    localparam int INT_TIMER1 = 3;

    // Standard 8051 vector addresses, one per source
    localparam logic [7:0] INT_VECTOR0 = 8'h03;
    localparam logic [7:0] INT_VECTOR1 = 8'h0B;
    localparam logic [7:0] INT_VECTOR2 = 8'h13;
    localparam logic [7:0] INT_VECTOR3 = 8'h1B;

endpackage

`default_nettype wire

// File: hw/sfr_control_regs.sv
// ==============================
// IE, IP, TMOD and TCON control registers
// TCON timer flags set from overflow pulses
// ==============================
`timescale 1ns/1ps
`default_nettype none

module sfr_control_regs (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   wr_stb_i,
    input  wire                                   wr_we_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] wr_adr_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] wr_dat_i,
    input  wire                                   timer0_trigger_i,
    input  wire                                   timer1_trigger_i,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] ie_o,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] ip_o,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] tmod_o,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] tcon_o
);

    logic wr_en;

    // Write takes effect at the edge with strobe and enable high
    assign wr_en = wr_stb_i && wr_we_i;

    // ==============================
    // Plain bus registers
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ie_o   <= '0;
            ip_o   <= '0;
            tmod_o <= '0;
        end else if (wr_en) begin
            case (wr_adr_i)
                sfr_pkg::IE_ADDR:   ie_o   <= wr_dat_i;
                sfr_pkg::IP_ADDR:   ip_o   <= wr_dat_i;
                sfr_pkg::TMOD_ADDR: tmod_o <= wr_dat_i;
                default: ;
            endcase
        end
    end

    // ==============================
    // TCON
    // ==============================
    // Bus write wins over a flag set in the same cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tcon_o <= '0;
        end else if (wr_en && (wr_adr_i == sfr_pkg::TCON_ADDR)) begin
            tcon_o <= wr_dat_i;
        end else begin
            // Both flags may rise together
            if (timer0_trigger_i) begin
                tcon_o[sfr_pkg::TCON_TF0_INDEX] <= 1'b1;
            end
            if (timer1_trigger_i) begin
                tcon_o[sfr_pkg::TCON_TF1_INDEX] <= 1'b1;
            end
        end
    end

    // Overflow pulses from the timers last one cycle
    trig0_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        timer0_trigger_i |=> !timer0_trigger_i);
    trig1_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        timer1_trigger_i |=> !timer1_trigger_i);

endmodule

`default_nettype wire

// File: hw/timer_8051.sv
// ==============================
// 8051 timer/counter, TH/TL registers
// Modes 1 and 2, registered overflow pulse
// ==============================
`timescale 1ns/1ps
`default_nettype none

module timer_8051 #(
    parameter logic [periph_pkg::DATA_WIDTH - 1 : 0] REG_ADDR_TH = sfr_pkg::TH0_ADDR,
    parameter logic [periph_pkg::DATA_WIDTH - 1 : 0] REG_ADDR_TL = sfr_pkg::TL0_ADDR
) (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   wr_stb_i,
    input  wire                                   wr_we_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] wr_adr_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] wr_dat_i,
    input  wire  [3 : 0]                          tmod_nibble_i,
    input  wire                                   run_i,
    input  wire                                   gate_pin_i,
    input  wire                                   event_pulse_i,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] th_o,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] tl_o,
    output logic                                  timer_trigger_o
);

    logic gate;
    logic c_t;
    logic mode2;
    logic wr_th;
    logic wr_tl;
    logic count_en;
    logic wrap;

    // ==============================
    // Mode decode
    // ==============================
    assign gate  = tmod_nibble_i[sfr_pkg::TMOD_GATE_INDEX];
    assign c_t   = tmod_nibble_i[sfr_pkg::TMOD_C_T_INDEX];
    // Mode 2 is M1 M0 = 10, modes 0 and 3 fall back to mode 1
    assign mode2 = tmod_nibble_i[sfr_pkg::TMOD_M1_INDEX] &&
                   !tmod_nibble_i[sfr_pkg::TMOD_M0_INDEX];

    assign wr_th = wr_stb_i && wr_we_i && (wr_adr_i == REG_ADDR_TH);
    assign wr_tl = wr_stb_i && wr_we_i && (wr_adr_i == REG_ADDR_TL);

    // Run bit, gate pin when GATE set, event pulses in counter mode
    assign count_en = run_i && (!gate || gate_pin_i) && (!c_t || event_pulse_i);

    // Next count rolls over
    assign wrap = mode2 ? (tl_o == '1) : ({th_o, tl_o} == '1);

    // ==============================
    // Count registers
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            th_o <= '0;
            tl_o <= '0;
        end else if (wr_th || wr_tl) begin
            // Bus write holds the count for this cycle
            if (wr_th) begin
                th_o <= wr_dat_i;
            end
            if (wr_tl) begin
                tl_o <= wr_dat_i;
            end
        end else if (count_en) begin
            if (mode2) begin
                // 8 bit auto-reload from TH
                tl_o <= wrap ? th_o : tl_o + 1'b1;
            end else begin
                {th_o, tl_o} <= {th_o, tl_o} + 1'b1;
            end
        end
    end

    // Overflow pulse, one cycle after the wrapping edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timer_trigger_o <= 1'b0;
        end else begin
            timer_trigger_o <= count_en && wrap && !(wr_th || wr_tl);
        end
    end

    trigger_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        timer_trigger_o |=> !timer_trigger_o);

endmodule

`default_nettype wire

// File: hw/interrupt_ctrl.sv
// ==============================
// Two-level priority interrupt controller
// ==============================
`timescale 1ns/1ps
`default_nettype none

module interrupt_ctrl (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire  [periph_pkg::NUM_OF_INT - 1 : 0] int_pins_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] ie_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0] ip_i,
    input  wire                                   interrupt_return_i,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0] int_addr_o,
    output logic                                  int_gen_o
);

    localparam int N     = periph_pkg::NUM_OF_INT;
    localparam int IDX_W = $clog2(N);
    // Timer sources arrive as pulses, external ones as levels
    localparam logic [N - 1 : 0] PULSE_SRC =
        N'((1 << periph_pkg::INT_TIMER0) | (1 << periph_pkg::INT_TIMER1));

    logic [N - 1 : 0]     enable_mask;
    logic [N - 1 : 0]     pending_q;
    logic [N - 1 : 0]     eligible;
    logic [N - 1 : 0]     hi_req;
    logic [N - 1 : 0]     lo_req;
    logic [N - 1 : 0]     served;
    logic [IDX_W - 1 : 0] sel;
    logic                 take;
    logic                 take_hi;
    // Bit 1 high level active, bit 0 low level active
    logic [1 : 0]         active_q;

    function automatic logic [IDX_W - 1 : 0] lowest_index(input logic [N - 1 : 0] req);
        logic [IDX_W - 1 : 0] idx;
        idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [periph_pkg::DATA_WIDTH - 1 : 0] vector_of(
        input logic [IDX_W - 1 : 0] idx);
        case (idx)
            periph_pkg::INT_EXT0:   return periph_pkg::INT_VECTOR0;
            periph_pkg::INT_TIMER0: return periph_pkg::INT_VECTOR1;
            periph_pkg::INT_EXT1:   return periph_pkg::INT_VECTOR2;
            default:                return periph_pkg::INT_VECTOR3;
        endcase
    endfunction

    // ==============================
    // Eligibility
    // ==============================
    assign enable_mask[periph_pkg::INT_EXT0]   = ie_i[sfr_pkg::IE_EX0_INDEX];
    assign enable_mask[periph_pkg::INT_TIMER0] = ie_i[sfr_pkg::IE_ET0_INDEX];
    assign enable_mask[periph_pkg::INT_EXT1]   = ie_i[sfr_pkg::IE_EX1_INDEX];
    assign enable_mask[periph_pkg::INT_TIMER1] = ie_i[sfr_pkg::IE_ET1_INDEX];

    assign eligible = pending_q & enable_mask & {N{ie_i[sfr_pkg::IE_EA_INDEX]}};
    assign hi_req   = eligible & ip_i[N - 1 : 0];
    assign lo_req   = eligible & ~ip_i[N - 1 : 0];

    // High request needs no high level active, low needs an idle stack
    always_comb begin
        take    = 1'b0;
        take_hi = 1'b0;
        sel     = '0;
        served  = '0;
        // One idle cycle between vectors
        if (!int_gen_o) begin
            if (!active_q[1] && |hi_req) begin
                take    = 1'b1;
                take_hi = 1'b1;
                sel     = lowest_index(hi_req);
            end else if ((active_q == 2'b00) && |lo_req) begin
                take = 1'b1;
                sel  = lowest_index(lo_req);
            end
        end
        served[sel] = take;
    end

    // ==============================
    // Pending, stack and vector
    // ==============================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending_q <= '0;
        end else begin
            // Pulses latch until served, levels follow the pin
            pending_q <= (int_pins_i & ~PULSE_SRC) |
                         (((pending_q & ~served) | int_pins_i) & PULSE_SRC);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active_q   <= 2'b00;
            int_gen_o  <= 1'b0;
            int_addr_o <= '0;
        end else begin
            int_gen_o <= take;
            if (take) begin
                int_addr_o <= vector_of(sel);
            end
            // Return ends the innermost level
            if (interrupt_return_i) begin
                if (active_q[1]) begin
                    active_q[1] <= 1'b0;
                end else begin
                    active_q[0] <= 1'b0;
                end
            end
            if (take) begin
                active_q[take_hi] <= 1'b1;
            end
        end
    end

    // A return needs an active level to end
    return_with_level: assert property (@(posedge clk) disable iff (!reset_n)
        interrupt_return_i |-> (active_q != 2'b00));

endmodule

`default_nettype wire

// File: hw/peripherals_top.sv
// ==============================
// Timer/interrupt SFR block top level
// Read mux, pin synchronizer, timer-0 toggle output
// ==============================
`timescale 1ns/1ps
`default_nettype none

module peripherals_top (
    input  wire                                    clk,
    input  wire                                    reset_n,
    // Write bus
    input  wire                                    wb_wr_stb_i,
    input  wire                                    wb_wr_we_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0]  wb_wr_adr_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0]  wb_wr_dat_i,
    output logic                                   wb_wr_ack_o,
    // Read bus
    input  wire                                    wb_rd_stb_i,
    input  wire  [periph_pkg::DATA_WIDTH - 1 : 0]  wb_rd_adr_i,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0]  wb_rd_dat_o,
    output logic                                   wb_rd_ack_o,
    // Interrupts and timer pins
    input  wire  [periph_pkg::NUM_OF_INTX - 1 : 0] int_x_i,
    input  wire                                    interrupt_return_i,
    input  wire                                    timer_event_pulse_i,
    output logic [periph_pkg::DATA_WIDTH - 1 : 0]  int_addr_o,
    output logic                                   int_gen_o,
    output logic                                   timer_pulse_out_o
);

    logic [periph_pkg::DATA_WIDTH - 1 : 0]  ie, ip, tmod, tcon;
    logic [periph_pkg::DATA_WIDTH - 1 : 0]  th0, tl0, th1, tl1;
    logic                                   timer0_trigger, timer1_trigger;
    logic [periph_pkg::NUM_OF_INTX - 1 : 0] int_x_meta, int_x_sync;
    logic [periph_pkg::NUM_OF_INT - 1 : 0]  int_pins;

    // No wait states on either bus
    assign wb_wr_ack_o = wb_wr_stb_i;
    assign wb_rd_ack_o = wb_rd_stb_i;

    // ==============================
    // Read mux
    // ==============================
    always_comb begin
        case (wb_rd_adr_i)
            sfr_pkg::IE_ADDR:   wb_rd_dat_o = ie;
            sfr_pkg::IP_ADDR:   wb_rd_dat_o = ip;
            sfr_pkg::TMOD_ADDR: wb_rd_dat_o = tmod;
            sfr_pkg::TCON_ADDR: wb_rd_dat_o = tcon;
            sfr_pkg::TH0_ADDR:  wb_rd_dat_o = th0;
            sfr_pkg::TL0_ADDR:  wb_rd_dat_o = tl0;
            sfr_pkg::TH1_ADDR:  wb_rd_dat_o = th1;
            sfr_pkg::TL1_ADDR:  wb_rd_dat_o = tl1;
            default:            wb_rd_dat_o = '0;
        endcase
    end

    sfr_control_regs u_regs (
        .clk              (clk),
        .reset_n          (reset_n),
        .wr_stb_i         (wb_wr_stb_i),
        .wr_we_i          (wb_wr_we_i),
        .wr_adr_i         (wb_wr_adr_i),
        .wr_dat_i         (wb_wr_dat_i),
        .timer0_trigger_i (timer0_trigger),
        .timer1_trigger_i (timer1_trigger),
        .ie_o             (ie),
        .ip_o             (ip),
        .tmod_o           (tmod),
        .tcon_o           (tcon)
    );

    // ==============================
    // Timers
    // ==============================
    // INT0 gates timer 0, INT1 gates timer 1
    timer_8051 #(
        .REG_ADDR_TH (sfr_pkg::TH0_ADDR),
        .REG_ADDR_TL (sfr_pkg::TL0_ADDR)
    ) timer0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .wr_stb_i        (wb_wr_stb_i),
        .wr_we_i         (wb_wr_we_i),
        .wr_adr_i        (wb_wr_adr_i),
        .wr_dat_i        (wb_wr_dat_i),
        .tmod_nibble_i   (tmod[sfr_pkg::TMOD_T0_SHIFT +: 4]),
        .run_i           (tcon[sfr_pkg::TCON_TR0_INDEX]),
        .gate_pin_i      (int_x_sync[0]),
        .event_pulse_i   (timer_event_pulse_i),
        .th_o            (th0),
        .tl_o            (tl0),
        .timer_trigger_o (timer0_trigger)
    );

    timer_8051 #(
        .REG_ADDR_TH (sfr_pkg::TH1_ADDR),
        .REG_ADDR_TL (sfr_pkg::TL1_ADDR)
    ) timer1 (
        .clk             (clk),
        .reset_n         (reset_n),
        .wr_stb_i        (wb_wr_stb_i),
        .wr_we_i         (wb_wr_we_i),
        .wr_adr_i        (wb_wr_adr_i),
        .wr_dat_i        (wb_wr_dat_i),
        .tmod_nibble_i   (tmod[sfr_pkg::TMOD_T1_SHIFT +: 4]),
        .run_i           (tcon[sfr_pkg::TCON_TR1_INDEX]),
        .gate_pin_i      (int_x_sync[1]),
        .event_pulse_i   (timer_event_pulse_i),
        .th_o            (th1),
        .tl_o            (tl1),
        .timer_trigger_o (timer1_trigger)
    );

    // Toggle output, flips on each timer-0 overflow
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timer_pulse_out_o <= 1'b0;
        end else if (timer0_trigger) begin
            timer_pulse_out_o <= ~timer_pulse_out_o;
        end
    end

    // ==============================
    // Interrupts
    // ==============================
    // Two-stage synchronizer for the external pins
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            int_x_meta <= '0;
            int_x_sync <= '0;
        end else begin
            int_x_meta <= int_x_i;
            int_x_sync <= int_x_meta;
        end
    end

    assign int_pins[periph_pkg::INT_EXT0]   = int_x_sync[0];
    assign int_pins[periph_pkg::INT_TIMER0] = timer0_trigger;
    assign int_pins[periph_pkg::INT_EXT1]   = int_x_sync[1];
    assign int_pins[periph_pkg::INT_TIMER1] = timer1_trigger;

    interrupt_ctrl u_int_ctrl (
        .clk                (clk),
        .reset_n            (reset_n),
        .int_pins_i         (int_pins),
        .ie_i               (ie),
        .ip_i               (ip),
        .interrupt_return_i (interrupt_return_i),
        .int_addr_o         (int_addr_o),
        .int_gen_o          (int_gen_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_peripherals.sv
// ==============================
// Testbench for the timer/interrupt SFR block
// Plays the tests file against the DUT
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_peripherals;

    // Cycles allowed for an interrupt to show up
    localparam int WAIT_LIMIT = 50;

    logic       clk;
    logic       reset_n;
    logic       wr_stb;
    logic       wr_we;
    logic [7:0] wr_adr;
    logic [7:0] wr_dat;
    logic       wr_ack;
    logic       rd_stb;
    logic [7:0] rd_adr;
    logic [7:0] rd_dat;
    logic       rd_ack;
    logic [1:0] int_x;
    logic       int_ret;
    logic       event_pulse;
    logic [7:0] int_addr;
    logic       int_gen;
    logic       pulse_out;

    peripherals_top dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .wb_wr_stb_i         (wr_stb),
        .wb_wr_we_i          (wr_we),
        .wb_wr_adr_i         (wr_adr),
        .wb_wr_dat_i         (wr_dat),
        .wb_wr_ack_o         (wr_ack),
        .wb_rd_stb_i         (rd_stb),
        .wb_rd_adr_i         (rd_adr),
        .wb_rd_dat_o         (rd_dat),
        .wb_rd_ack_o         (rd_ack),
        .int_x_i             (int_x),
        .interrupt_return_i  (int_ret),
        .timer_event_pulse_i (event_pulse),
        .int_addr_o          (int_addr),
        .int_gen_o           (int_gen),
        .timer_pulse_out_o   (pulse_out)
    );

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s is %02h, expected %02h",
                                $time, name, actual, expected));
        end
    endtask

    // Drive point, 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // ==============================
    // Bus and pin operations
    // ==============================
    task automatic write_reg(input logic [7:0] adr, input logic [7:0] dat);
        next_cycle();
        wr_stb = 1'b1;
        wr_we  = 1'b1;
        wr_adr = adr;
        wr_dat = dat;
        #2;
        check_value("wb_wr_ack_o", {7'b0, wr_ack}, 8'h01);
        next_cycle();
        wr_stb = 1'b0;
        wr_we  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] adr, input logic [7:0] expected);
        next_cycle();
        rd_stb = 1'b1;
        rd_adr = adr;
        // Read data is combinational, sample late in the cycle
        #2;
        check_value("wb_rd_ack_o", {7'b0, rd_ack}, 8'h01);
        check_value("wb_rd_dat_o", rd_dat, expected);
        next_cycle();
        rd_stb = 1'b0;
    endtask

    // One high cycle and one low cycle per event
    task automatic pulse_events(input logic [7:0] count);
        repeat (count) begin
            next_cycle();
            event_pulse = 1'b1;
            next_cycle();
            event_pulse = 1'b0;
        end
    endtask

    task automatic pulse_return();
        next_cycle();
        int_ret = 1'b1;
        next_cycle();
        int_ret = 1'b0;
    endtask

    task automatic wait_interrupt(input logic [7:0] expected);
        int waited;
        waited = 0;
        next_cycle();
        #2;
        while (!int_gen && waited < WAIT_LIMIT) begin
            next_cycle();
            #2;
            waited++;
        end
        if (!int_gen) begin
            abort_run("Timed out waiting for int_gen_o");
        end
        check_value("int_addr_o", int_addr, expected);
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic run_op(input logic [7:0] op, input logic [7:0] adr,
                          input logic [7:0] dat, input logic [7:0] expected);
        case (op)
            "W": write_reg(adr, dat);
            "R": read_reg(adr, expected);
            "V": pulse_events(dat);
            "X": begin
                next_cycle();
                int_x = dat[1:0];
            end
            "C": repeat (dat) next_cycle();
            "G": wait_interrupt(expected);
            "Q": pulse_return();
            "T": check_value("timer_pulse_out_o", {7'b0, pulse_out}, expected);
            default: abort_run("Unknown operation letter in the tests file");
        endcase
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int         fd;
        int         n;
        logic       done;
        logic [7:0] op;
        logic [7:0] adr;
        logic [7:0] dat;
        logic [7:0] expected;
        reset_n     = 1'b0;
        wr_stb      = 1'b0;
        wr_we       = 1'b0;
        wr_adr      = '0;
        wr_dat      = '0;
        rd_stb      = 1'b0;
        rd_adr      = '0;
        int_x       = '0;
        int_ret     = 1'b0;
        event_pulse = 1'b0;
        done        = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // Idle bus, no acks
        #2;
        check_value("wb_wr_ack_o", {7'b0, wr_ack}, 8'h00);
        check_value("wb_rd_ack_o", {7'b0, rd_ack}, 8'h00);
        fd = $fopen("verification/peripherals_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the tests file");
        end
        while (!done) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                skip_line(fd);
            end else begin
                n = $fscanf(fd, " %h %h %h", adr, dat, expected);
                if (n != 3) begin
                    abort_run("Malformed line in the tests file");
                end
                run_op(op, adr, dat, expected);
            end
        end
        $fclose(fd);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/peripherals_tests.txt
# op addr data expected, all hex; W write, R read, V event pulses, X int_x_i
# C idle cycles, G wait for int_gen_o, Q interrupt return, T timer_pulse_out_o
# Reset values and an unmapped address
R 88 00 00
R 89 00 00
R 8A 00 00
R 8B 00 00
R 8C 00 00
R 8D 00 00
R A8 00 00
R B8 00 00
R 80 00 00
# Register read back
W A8 0A 00
W B8 05 00
W 89 21 00
W 8C 3C 00
W 8A C3 00
W 8D 5A 00
W 8B A5 00
R A8 00 0A
R B8 00 05
R 89 00 21
R 8C 00 3C
R 8A 00 C3
R 8D 00 5A
R 8B 00 A5
# Timer 0 mode 1 counter, overflow raises the timer-0 vector
W B8 00 00
W A8 82 00
W 89 65 00
W 8A FE 00
W 8C FF 00
W 88 10 00
V 00 02 00
G 00 00 0B
R 8C 00 00
R 8A 00 00
R 88 00 30
T 00 00 01
# Timer 1 mode 2 counter with reload from TH1
W 8D F0 00
W 8B FE 00
W 88 70 00
V 00 03 00
R 8B 00 F1
R 8D 00 F0
R 88 00 F0
R 8A 00 03
T 00 00 01
# Low-priority timer 1 waits behind the active timer-0 level
W B8 04 00
W A8 8E 00
C 00 0A 00
# High-priority external 1 preempts
X 00 02 00
G 00 00 13
X 00 00 00
C 00 04 00
Q 00 00 00
C 00 0A 00
Q 00 00 00
G 00 00 1B
# Gate 0 set with int_x_i[0] low holds timer 0
W 89 69 00
R 8A 00 03
C 00 14 00
R 8A 00 03

// File: files.f
hw/sfr_pkg.sv
hw/periph_pkg.sv
hw/sfr_control_regs.sv
hw/timer_8051.sv
hw/interrupt_ctrl.sv
hw/peripherals_top.sv
verification/tb_peripherals.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_peripherals \
    -f files.f \
    -Mdir obj_dir \
    -o sim_peripherals

./obj_dir/sim_peripherals
